/* hdl/via_params.svh */
// Register map and control bit positions of the 6522-style interface adapter
`ifndef VIA_PARAMS_SVH
`define VIA_PARAMS_SVH

// Register select codes
`define VIA_RS_ORB      4'h0
`define VIA_RS_ORA      4'h1
`define VIA_RS_DDRB     4'h2
`define VIA_RS_DDRA     4'h3
`define VIA_RS_T1CL     4'h4
`define VIA_RS_T1CH     4'h5
`define VIA_RS_T1LL     4'h6
`define VIA_RS_T1LH     4'h7
`define VIA_RS_T2CL     4'h8
`define VIA_RS_T2CH     4'h9
`define VIA_RS_SR       4'hA
`define VIA_RS_ACR      4'hB
`define VIA_RS_PCR      4'hC
`define VIA_RS_IFR      4'hD
`define VIA_RS_IER      4'hE
`define VIA_RS_ORA_NH   4'hF

// ACR fields
`define VIA_ACR_PB7EN       7
`define VIA_ACR_FREERUN     6
`define VIA_ACR_SRMODE_LO   2

// Shift register modes held in ACR bits 4..2
`define VIA_SR_MODE0    3'b000
`define VIA_SR_MODE2    3'b010

// PCR edge polarity, 1 selects rising
`define VIA_PCR_CA1POS  0
`define VIA_PCR_CA2POS  2
`define VIA_PCR_CB1POS  4
`define VIA_PCR_CB2POS  6

// PCR independent-interrupt bits of CA2 and CB2
`define VIA_PCR_CA2IND  1
`define VIA_PCR_CB2IND  5

// IFR and IER bit indices
`define VIA_IFR_CA2     0
`define VIA_IFR_CA1     1
`define VIA_IFR_SR      2
`define VIA_IFR_CB2     3
`define VIA_IFR_CB1     4
`define VIA_IFR_T1      6

`endif

/* hdl/viaPkg.sv */
// Shared bus, port pin and configuration types of the interface adapter
package viaPkg;

	// One host access
	// Valid only in the cycle where strobe is high
	typedef struct packed {
		logic       strobe;
		logic       write;
		logic [3:0] rs;
		logic [7:0] wdata;
	} busReq_t;

	// Pin side of one 8-bit port
	// Tristate buffers sit outside the adapter
	typedef struct packed {
		logic [7:0] pinsOut;
		logic [7:0] pinsOe;
	} portPins_t;

	// Edge pulses of one control line
	typedef struct packed {
		logic rise;
		logic fall;
	} ctrlEdges_t;

	// Auxiliary and peripheral control bytes
	// Shared with timer and shifter
	typedef struct packed {
		logic [7:0] acr;
		logic [7:0] pcr;
	} regCfg_t;

endpackage

/* hdl/viaEdgeDetect.sv */
// Control line synchronizer that reports single-cycle rising and falling edges
`timescale 1ns/1ns

module viaEdgeDetect (
	input  logic                clk,
	input  logic                nRESET,
	input  logic                line,
	output viaPkg::ctrlEdges_t  edges
);

	// hist[0] is the synchronized level, hist[1] the level one cycle older
	logic [1:0] hist;

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			hist <= 2'b00;
			edges <= '0;
		end else begin
			hist <= {hist[0], line};
			// Registered compare
			edges.rise <= hist[0] & ~hist[1];
			edges.fall <= ~hist[0] & hist[1];
		end
	end

endmodule

/* hdl/viaTimer1.sv */
// Timer 1 with latch reload, one-shot or free-running expiry and PB7 output
`timescale 1ns/1ns
`include "via_params.svh"

module viaTimer1 (
	input  logic             clk,
	input  logic             nRESET,
	input  logic             clkEn,
	input  viaPkg::regCfg_t  cfg,
	input  logic [7:0]       wdata,
	input  logic             t1LoadLo,
	input  logic             t1LoadHi,
	input  logic             t1Ack,
	output logic [15:0]      t1Count,
	output logic [15:0]      t1Latch,
	output logic             t1Expire,
	output logic             pb7
);

	logic freeRun;
	// One-shot interrupt still pending since the last T1CH write
	logic armed;

	assign freeRun = cfg.acr[`VIA_ACR_FREERUN];

	// Latch bytes from the bus
	always_ff @(posedge clk) begin
		if (!nRESET) begin
			t1Latch <= '0;
		end else begin
			if (t1LoadLo) begin
				t1Latch[7:0] <= wdata;
			end
			if (t1LoadHi) begin
				t1Latch[15:8] <= wdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			t1Count <= '0;
			armed <= 1'b0;
			t1Expire <= 1'b0;
			pb7 <= 1'b0;
		end else begin
			t1Expire <= 1'b0;
			if (t1Ack) begin
				// T1CH write starts the count with the new high byte
				t1Count <= {wdata, t1Latch[7:0]};
				armed <= 1'b1;
				pb7 <= 1'b0;
			end else if (clkEn) begin
				if (t1Count == 16'd0) begin
					t1Count <= t1Latch;
					if (freeRun) begin
						t1Expire <= 1'b1;
						pb7 <= ~pb7;
					end else if (armed) begin
						// Single shot per start
						t1Expire <= 1'b1;
						pb7 <= 1'b1;
						armed <= 1'b0;
					end
				end else begin
					t1Count <= t1Count - 16'd1;
				end
			end
		end
	end

	// An expiry in the restart cycle would leave a stale T1 flag
	assert property (@(posedge clk) disable iff (!nRESET) !(t1Ack && t1Expire))
		else $error("viaTimer1: expiry in the same cycle as a T1CH load");

endmodule

/* hdl/viaShifter.sv */
// Shift-in register clocked by external CB1 edges or by an internal CB1 clock
`timescale 1ns/1ns
`include "via_params.svh"

module viaShifter (
	input  logic             clk,
	input  logic             nRESET,
	input  logic             clkEn,
	input  viaPkg::regCfg_t  cfg,
	input  logic             srLoad,
	input  logic [7:0]       wdata,
	input  logic             cb1In,
	input  logic             cb2In,
	input  logic             cb1Rise,
	output logic [7:0]       srData,
	output logic             srDone,
	output logic             cb1Out,
	output logic             cb1Oe
);

	logic [2:0] srMode;
	logic       isMode0;
	logic       isMode2;
	logic [7:0] shiftReg;
	logic [2:0] bitCount;
	logic       active;
	// Internal CB1 clock, idles high
	logic       shiftClk;
	logic       shiftNow;

	assign srMode = cfg.acr[`VIA_ACR_SRMODE_LO +: 3];
	assign isMode0 = (srMode == `VIA_SR_MODE0);
	assign isMode2 = (srMode == `VIA_SR_MODE2);

	// Sample CB2 on the low-to-high of our clock or on an external CB1 rise
	assign shiftNow = active & ((isMode2 & clkEn & ~shiftClk) | (isMode0 & cb1Rise));

	always_ff @(posedge clk) begin
		if (srLoad) begin
			shiftReg <= wdata;
		end else if (shiftNow) begin
			shiftReg <= {shiftReg[6:0], cb2In};
		end
	end

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			active <= 1'b0;
			bitCount <= 3'd0;
			shiftClk <= 1'b1;
			srDone <= 1'b0;
			cb1Oe <= 1'b0;
		end else begin
			srDone <= 1'b0;
			cb1Oe <= isMode2;
			if (srLoad) begin
				active <= 1'b1;
				bitCount <= 3'd0;
				shiftClk <= 1'b1;
			end else begin
				if (isMode2 && active && clkEn) begin
					shiftClk <= ~shiftClk;
				end
				if (shiftNow) begin
					bitCount <= bitCount + 3'd1;
					// Eighth bit ends the transfer
					if (bitCount == 3'd7) begin
						active <= 1'b0;
						srDone <= 1'b1;
					end
				end
			end
		end
	end

	assign srData = shiftReg;

	// Level of the CB1 line as the adapter sees it
	assign cb1Out = cb1Oe ? shiftClk : cb1In;

	// Own-clock shifts happen only while CB1 is driven
	assert property (@(posedge clk) disable iff (!nRESET) (shiftNow && isMode2) |-> cb1Oe)
		else $error("viaShifter: internal shift clock used while CB1 is not driven");

endmodule

/* hdl/viaRegisterFile.sv */
// Register decode, port registers, interrupt flags and enables, read mux and irq
`timescale 1ns/1ns
`include "via_params.svh"

module viaRegisterFile (
	input  logic                clk,
	input  logic                nRESET,
	input  viaPkg::busReq_t     bus,
	input  logic [7:0]          portAIn,
	input  logic [7:0]          portBIn,
	input  viaPkg::ctrlEdges_t  ca1,
	input  viaPkg::ctrlEdges_t  ca2,
	input  viaPkg::ctrlEdges_t  cb1,
	input  viaPkg::ctrlEdges_t  cb2,
	input  logic [15:0]         t1Count,
	input  logic [15:0]         t1Latch,
	input  logic                t1Expire,
	input  logic                pb7,
	input  logic [7:0]          srData,
	input  logic                srDone,
	output viaPkg::regCfg_t     cfg,
	output logic                t1LoadLo,
	output logic                t1LoadHi,
	output logic                t1Ack,
	output logic                srLoad,
	output viaPkg::portPins_t   portA,
	output viaPkg::portPins_t   portB,
	output logic [7:0]          rdData,
	output logic                rdValid,
	output logic                nIrq
);

	logic       rdStrobe;
	logic       wrStrobe;
	logic [7:0] ora;
	logic [7:0] orb;
	logic [7:0] ddra;
	logic [7:0] ddrb;
	logic [7:0] acr;
	logic [7:0] pcr;
	logic [6:0] ifr;
	logic [6:0] ier;
	logic [6:0] ifrSet;
	logic [6:0] ifrClr;
	logic [7:0] orbEff;
	logic [7:0] portARead;
	logic [7:0] portBRead;
	logic [7:0] rdNext;
	logic       ca2Indep;
	logic       cb2Indep;
	logic       accessOra;
	logic       accessOrb;
	logic       irqActive;

	function automatic logic pickEdge(input viaPkg::ctrlEdges_t e, input logic rising);
		pickEdge = rising ? e.rise : e.fall;
	endfunction

	assign rdStrobe = bus.strobe & ~bus.write;
	assign wrStrobe = bus.strobe & bus.write;

	// Timer and shifter strobes, consumed at the same clock edge
	assign t1LoadLo = wrStrobe & (bus.rs == `VIA_RS_T1CL || bus.rs == `VIA_RS_T1LL);
	assign t1LoadHi = wrStrobe & (bus.rs == `VIA_RS_T1CH || bus.rs == `VIA_RS_T1LH);
	assign t1Ack = wrStrobe & (bus.rs == `VIA_RS_T1CH);
	assign srLoad = wrStrobe & (bus.rs == `VIA_RS_SR);

	assign cfg.acr = acr;
	assign cfg.pcr = pcr;

	// Timer 1 takes over PB7 when enabled in ACR
	assign orbEff = {acr[`VIA_ACR_PB7EN] ? pb7 : orb[7], orb[6:0]};

	assign portA.pinsOut = ora;
	assign portA.pinsOe = ddra;
	assign portB.pinsOut = orbEff;
	assign portB.pinsOe = {ddrb[7] | acr[`VIA_ACR_PB7EN], ddrb[6:0]};

	assign portARead = (ora & ddra) | (portAIn & ~ddra);
	assign portBRead = (orbEff & portB.pinsOe) | (portBIn & ~portB.pinsOe);

	assign ca2Indep = pcr[`VIA_PCR_CA2IND] & ~pcr[`VIA_PCR_CA2POS + 1];
	assign cb2Indep = pcr[`VIA_PCR_CB2IND] & ~pcr[`VIA_PCR_CB2POS + 1];
	// ORA without handshake leaves the CA flags alone
	assign accessOra = bus.strobe & (bus.rs == `VIA_RS_ORA);
	assign accessOrb = bus.strobe & (bus.rs == `VIA_RS_ORB);

	assign irqActive = |(ifr & ier);

	always_comb begin
		ifrSet = '0;
		ifrSet[`VIA_IFR_CA2] = pickEdge(ca2, pcr[`VIA_PCR_CA2POS]);
		ifrSet[`VIA_IFR_CA1] = pickEdge(ca1, pcr[`VIA_PCR_CA1POS]);
		ifrSet[`VIA_IFR_SR] = srDone;
		ifrSet[`VIA_IFR_CB2] = pickEdge(cb2, pcr[`VIA_PCR_CB2POS]);
		ifrSet[`VIA_IFR_CB1] = pickEdge(cb1, pcr[`VIA_PCR_CB1POS]);
		ifrSet[`VIA_IFR_T1] = t1Expire;
	end

	always_comb begin
		ifrClr = '0;
		if (wrStrobe && bus.rs == `VIA_RS_IFR) begin
			ifrClr = bus.wdata[6:0];
		end
		if (accessOra) begin
			ifrClr[`VIA_IFR_CA1] = 1'b1;
			ifrClr[`VIA_IFR_CA2] = ifrClr[`VIA_IFR_CA2] | ~ca2Indep;
		end
		if (accessOrb) begin
			ifrClr[`VIA_IFR_CB1] = 1'b1;
			ifrClr[`VIA_IFR_CB2] = ifrClr[`VIA_IFR_CB2] | ~cb2Indep;
		end
		if ((rdStrobe && bus.rs == `VIA_RS_T1CL) || t1Ack) begin
			ifrClr[`VIA_IFR_T1] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			ora <= '0;
			orb <= '0;
			ddra <= '0;
			ddrb <= '0;
			acr <= '0;
			pcr <= '0;
			ifr <= '0;
			ier <= '0;
			nIrq <= 1'b1;
			rdValid <= 1'b0;
		end else begin
			if (wrStrobe) begin
				case (bus.rs)
					`VIA_RS_ORB: orb <= bus.wdata;
					`VIA_RS_ORA, `VIA_RS_ORA_NH: ora <= bus.wdata;
					`VIA_RS_DDRB: ddrb <= bus.wdata;
					`VIA_RS_DDRA: ddra <= bus.wdata;
					`VIA_RS_ACR: acr <= bus.wdata;
					`VIA_RS_PCR: pcr <= bus.wdata;
					// Bit 7 picks set or clear for the mask bits
					`VIA_RS_IER: ier <= bus.wdata[7] ? (ier | bus.wdata[6:0])
						: (ier & ~bus.wdata[6:0]);
					default: ;
				endcase
			end
			// New events win over a clear in the same cycle
			ifr <= (ifr & ~ifrClr) | ifrSet;
			nIrq <= ~irqActive;
			rdValid <= rdStrobe;
		end
	end

	always_comb begin
		rdNext = '0;
		case (bus.rs)
			`VIA_RS_ORB: rdNext = portBRead;
			`VIA_RS_ORA, `VIA_RS_ORA_NH: rdNext = portARead;
			`VIA_RS_DDRB: rdNext = ddrb;
			`VIA_RS_DDRA: rdNext = ddra;
			`VIA_RS_T1CL: rdNext = t1Count[7:0];
			`VIA_RS_T1CH: rdNext = t1Count[15:8];
			`VIA_RS_T1LL: rdNext = t1Latch[7:0];
			`VIA_RS_T1LH: rdNext = t1Latch[15:8];
			// No timer 2 in this subset
			`VIA_RS_T2CL, `VIA_RS_T2CH: rdNext = 8'h00;
			`VIA_RS_SR: rdNext = srData;
			`VIA_RS_ACR: rdNext = acr;
			`VIA_RS_PCR: rdNext = pcr;
			`VIA_RS_IFR: rdNext = {irqActive, ifr};
			`VIA_RS_IER: rdNext = {1'b1, ier};
			default: rdNext = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rdStrobe) begin
			rdData <= rdNext;
		end
	end

	// IFR bit 7 and nIrq come from the same irq state
	assert property (@(posedge clk) disable iff (!nRESET)
		(rdValid && $past(bus.rs) == `VIA_RS_IFR) |-> (rdData[7] == !nIrq))
		else $error("viaRegisterFile: IFR bit 7 read disagrees with nIrq");

endmodule

/* hdl/viaTop.sv */
// Top level of the 6522-style adapter joining registers, timer 1, shifter and edge detectors
`timescale 1ns/1ns

module viaTop (
	input  logic               clk,
	input  logic               nRESET,
	input  logic               clkEn,
	input  viaPkg::busReq_t    bus,
	output logic [7:0]         rdData,
	output logic               rdValid,
	output logic               nIrq,
	input  logic [7:0]         portAIn,
	input  logic [7:0]         portBIn,
	output viaPkg::portPins_t  portA,
	output viaPkg::portPins_t  portB,
	input  logic               ca1,
	input  logic               ca2,
	input  logic               cb1In,
	input  logic               cb2,
	output logic               cb1Out,
	output logic               cb1Oe
);

	viaPkg::ctrlEdges_t ca1Edges;
	viaPkg::ctrlEdges_t ca2Edges;
	viaPkg::ctrlEdges_t cb1Edges;
	viaPkg::ctrlEdges_t cb2Edges;
	viaPkg::regCfg_t    cfg;
	logic               t1LoadLo;
	logic               t1LoadHi;
	logic               t1Ack;
	logic               srLoad;
	logic [15:0]        t1Count;
	logic [15:0]        t1Latch;
	logic               t1Expire;
	logic               pb7;
	logic [7:0]         srData;
	logic               srDone;

	viaEdgeDetect ca1Detect (.clk(clk), .nRESET(nRESET), .line(ca1), .edges(ca1Edges));
	viaEdgeDetect ca2Detect (.clk(clk), .nRESET(nRESET), .line(ca2), .edges(ca2Edges));
	// CB1 is watched on the line level, which is our own clock in mode 2
	viaEdgeDetect cb1Detect (.clk(clk), .nRESET(nRESET), .line(cb1Out), .edges(cb1Edges));
	viaEdgeDetect cb2Detect (.clk(clk), .nRESET(nRESET), .line(cb2), .edges(cb2Edges));

	viaRegisterFile regs (
		.clk(clk),
		.nRESET(nRESET),
		.bus(bus),
		.portAIn(portAIn),
		.portBIn(portBIn),
		.ca1(ca1Edges),
		.ca2(ca2Edges),
		.cb1(cb1Edges),
		.cb2(cb2Edges),
		.t1Count(t1Count),
		.t1Latch(t1Latch),
		.t1Expire(t1Expire),
		.pb7(pb7),
		.srData(srData),
		.srDone(srDone),
		.cfg(cfg),
		.t1LoadLo(t1LoadLo),
		.t1LoadHi(t1LoadHi),
		.t1Ack(t1Ack),
		.srLoad(srLoad),
		.portA(portA),
		.portB(portB),
		.rdData(rdData),
		.rdValid(rdValid),
		.nIrq(nIrq)
	);

	viaTimer1 timer1 (
		.clk(clk),
		.nRESET(nRESET),
		.clkEn(clkEn),
		.cfg(cfg),
		.wdata(bus.wdata),
		.t1LoadLo(t1LoadLo),
		.t1LoadHi(t1LoadHi),
		.t1Ack(t1Ack),
		.t1Count(t1Count),
		.t1Latch(t1Latch),
		.t1Expire(t1Expire),
		.pb7(pb7)
	);

	viaShifter shifter (
		.clk(clk),
		.nRESET(nRESET),
		.clkEn(clkEn),
		.cfg(cfg),
		.srLoad(srLoad),
		.wdata(bus.wdata),
		.cb1In(cb1In),
		.cb2In(cb2),
		.cb1Rise(cb1Edges.rise),
		.srData(srData),
		.srDone(srDone),
		.cb1Out(cb1Out),
		.cb1Oe(cb1Oe)
	);

endmodule

/* test/viaTb.sv */
// Testbench that replays a command file of bus accesses and pin events against the adapter
`timescale 1ns/1ns

module viaTb;

	localparam int irqBudget = 300;
	localparam int maxCmds = 128;

	logic               clk;
	logic               nRESET;
	logic               clkEn;
	viaPkg::busReq_t    bus;
	logic [7:0]         rdData;
	logic               rdValid;
	logic               nIrq;
	logic [7:0]         portAIn;
	logic [7:0]         portBIn;
	viaPkg::portPins_t  portA;
	viaPkg::portPins_t  portB;
	logic               ca1;
	logic               ca2;
	logic               cb1In;
	logic               cb2;
	logic               cb1Out;
	logic               cb1Oe;

	// Command table loaded from the data file
	logic [63:0]  cmdOp [0:maxCmds-1];
	logic [127:0] cmdName [0:maxCmds-1];
	logic [7:0]   cmdSel [0:maxCmds-1];
	logic [7:0]   cmdData [0:maxCmds-1];
	logic [7:0]   cmdExp [0:maxCmds-1];
	int           cmdCount;

	int cycleCount;
	int cycleLimit;

	// Serial pattern fed onto cb2, MSB first
	logic [7:0] serialPattern;
	int         serialLeft;
	logic       prevCb1;

	viaTop viaTop_inst (
		.clk(clk),
		.nRESET(nRESET),
		.clkEn(clkEn),
		.bus(bus),
		.rdData(rdData),
		.rdValid(rdValid),
		.nIrq(nIrq),
		.portAIn(portAIn),
		.portBIn(portBIn),
		.portA(portA),
		.portB(portB),
		.ca1(ca1),
		.ca2(ca2),
		.cb1In(cb1In),
		.cb2(cb2),
		.cb1Out(cb1Out),
		.cb1Oe(cb1Oe)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abortRun();
		$display("TEST FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic checkValue(input logic [127:0] name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (expected !== actual) begin
			$display("error %0s expected %02h actual %02h", name, expected, actual);
			abortRun();
		end
	endtask

	task automatic loadCommands();
		int fd;
		int got;
		logic [8*120-1:0] lineBuf;
		logic [63:0] op;
		logic [127:0] name;
		logic [7:0] sel;
		logic [7:0] data;
		logic [7:0] expv;
		fd = $fopen("test/via_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open the command file test/via_testdata.txt");
			abortRun();
		end
		cmdCount = 0;
		while (!$feof(fd) && cmdCount < maxCmds) begin
			lineBuf = '0;
			got = $fgets(lineBuf, fd);
			got = $sscanf(lineBuf, "%s %s %h %h %h", op, name, sel, data, expv);
			// Comment and blank lines never yield five fields
			if (got == 5 && op != "#") begin
				cmdOp[cmdCount] = op;
				cmdName[cmdCount] = name;
				cmdSel[cmdCount] = sel;
				cmdData[cmdCount] = data;
				cmdExp[cmdCount] = expv;
				cmdCount++;
			end
		end
		$fclose(fd);
	endtask

	task automatic busWrite(input logic [3:0] rs, input logic [7:0] data);
		bus.strobe = 1'b1;
		bus.write = 1'b1;
		bus.rs = rs;
		bus.wdata = data;
		@(negedge clk);
		bus = '0;
		// Registered irq follows one cycle later
		@(negedge clk);
	endtask

	task automatic busRead(input logic [127:0] name, input logic [3:0] rs,
		input logic [7:0] mask, input logic [7:0] expected);
		int waited;
		bus.strobe = 1'b1;
		bus.write = 1'b0;
		bus.rs = rs;
		bus.wdata = 8'h00;
		@(negedge clk);
		bus = '0;
		waited = 0;
		while (!rdValid) begin
			if (waited >= 4) begin
				$display("read in test %0s got no rdValid response", name);
				abortRun();
			end
			@(negedge clk);
			waited++;
		end
		checkValue(name, expected, rdData & mask);
		@(negedge clk);
	endtask

	task automatic setPin(input logic [7:0] sel, input logic [7:0] value);
		case (sel)
			8'd0: portAIn = value;
			8'd1: portBIn = value;
			8'd2: ca1 = value[0];
			8'd3: ca2 = value[0];
			8'd4: cb1In = value[0];
			8'd5: cb2 = value[0];
			8'd6: begin
				serialPattern = value;
				serialLeft = 8;
			end
			default: begin
				$display("pin command names an unknown pin %0d", sel);
				abortRun();
			end
		endcase
		// Synchronizer, edge compare, flag and irq register
		repeat (4) @(negedge clk);
	endtask

	task automatic expectPin(input logic [127:0] name, input logic [7:0] sel,
		input logic [7:0] mask, input logic [7:0] expected);
		logic [7:0] value;
		value = 8'h00;
		case (sel)
			8'd0: value = portA.pinsOut;
			8'd1: value = portA.pinsOe;
			8'd2: value = portB.pinsOut;
			8'd3: value = portB.pinsOe;
			8'd4: value = {7'd0, nIrq};
			8'd5: value = {7'd0, cb1Oe};
			default: begin
				$display("expin command names an unknown output %0d", sel);
				abortRun();
			end
		endcase
		checkValue(name, expected, value & mask);
		@(negedge clk);
	endtask

	task automatic waitIrq(input logic [127:0] name);
		int waited;
		waited = 0;
		while (nIrq) begin
			if (waited >= irqBudget) begin
				$display("interrupt never arrived in test %0s", name);
				abortRun();
			end
			@(negedge clk);
			waited++;
		end
	endtask

	// Next cb2 bit goes out right after each falling cb1Out
	always @(negedge clk) begin
		if (serialLeft > 0 && prevCb1 && !cb1Out) begin
			cb2 = serialPattern[serialLeft - 1];
			serialLeft = serialLeft - 1;
		end
		prevCb1 = cb1Out;
	end

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleLimit > 0 && cycleCount > cycleLimit) begin
			$display("timeout after %0d cycles before the command list finished", cycleCount);
			abortRun();
		end
	end

	initial begin
		nRESET = 1'b0;
		clkEn = 1'b1;
		bus = '0;
		portAIn = 8'h00;
		portBIn = 8'h00;
		ca1 = 1'b0;
		ca2 = 1'b0;
		cb1In = 1'b1;
		cb2 = 1'b0;
		serialPattern = 8'h00;
		serialLeft = 0;
		prevCb1 = 1'b1;
		cycleCount = 0;
		cycleLimit = 0;
		loadCommands();
		if (cmdCount == 0) begin
			$display("command file test/via_testdata.txt holds no commands");
			abortRun();
		end
		cycleLimit = cmdCount * irqBudget;
		repeat (16) @(posedge clk);
		@(negedge clk);
		nRESET = 1'b1;
		for (int i = 0; i < cmdCount; i++) begin
			if (cmdOp[i] == "write") begin
				busWrite(cmdSel[i][3:0], cmdData[i]);
			end else if (cmdOp[i] == "read") begin
				busRead(cmdName[i], cmdSel[i][3:0], cmdData[i], cmdExp[i]);
			end else if (cmdOp[i] == "pin") begin
				setPin(cmdSel[i], cmdData[i]);
			end else if (cmdOp[i] == "waitirq") begin
				waitIrq(cmdName[i]);
			end else if (cmdOp[i] == "expin") begin
				expectPin(cmdName[i], cmdSel[i], cmdData[i], cmdExp[i]);
			end else begin
				$display("unknown command %0s in test %0s", cmdOp[i], cmdName[i]);
				abortRun();
			end
		end
		$display("TEST OK");
		$finish;
	end

endmodule

/* test/via_testdata.txt */
# op name select data expected, all numbers in hex, data is the mask for read and expin
# pin select: 0 portAIn 1 portBIn 2 ca1 3 ca2 4 cb1In 5 cb2 6 serial pattern on cb2
# expin select: 0 A pinsOut 1 A pinsOe 2 B pinsOut 3 B pinsOe 4 nIrq 5 cb1Oe
read    resetIfr    D FF 00
read    resetIer    E FF 80
expin   resetAOe    1 FF 00
expin   resetBOe    3 FF 00
expin   resetIrq    4 01 01
write   ddra        3 F0 00
write   ora         1 A5 00
read    ddraRd      3 FF F0
expin   portAOut    0 FF A5
expin   portAOe     1 FF F0
pin     portAIn     0 3C 00
read    oraMix      1 FF AC
# interrupt enable set and clear
write   ierSet1     E 83 00
read    ierRd1      E FF 83
write   ierSet2     E C0 00
read    ierRd2      E FF C3
write   ierClr      E 01 00
read    ierRd3      E FF C2
write   ierClrAll   E 7F 00
read    ierRd4      E FF 80
# control line CA1 on rising edge
write   pcrCa1Rise  C 01 00
write   ierCa1      E 82 00
pin     ca1High     2 01 00
waitirq ca1Irq      0 00 00
read    ifrCa1      D FF 82
expin   irqLow      4 01 00
write   ifrClr      D 02 00
expin   irqHigh     4 01 01
read    ifrClear    D FF 00
pin     ca1Fall     2 00 00
read    ifrNoFall   D FF 00
expin   irqStill    4 01 01
# timer 1 single shot
write   ierT1       E C0 00
write   t1ll        6 40 00
write   t1lh        7 00 00
write   t1ch        5 00 00
waitirq t1Irq       0 00 00
read    ifrT1       D C0 C0
read    t1cl        4 00 00
read    ifrT1Clr    D C0 00
expin   irqT1Off    4 01 01
# timer 1 free run with PB7
write   t1llFr      6 50 00
write   t1chFr      5 00 00
write   acrFree     B C0 00
expin   pb7Start    2 80 00
expin   pb7Oe       3 80 80
waitirq t1Exp1      0 00 00
expin   pb7First    2 80 80
read    t1ackA      4 00 00
waitirq t1Exp2      0 00 00
expin   pb7Second   2 80 00
read    t1ackB      4 00 00
# shift in under internal CB1 clock
write   acrShift    B 08 00
write   ierOff      E 7F 00
write   ifrFlush    D 7F 00
write   ierSr       E 84 00
expin   cb1Drive    5 01 01
pin     cb2Pattern  6 B6 00
write   srStart     A 00 00
expin   cb1Busy     5 01 01
waitirq srIrq       0 00 00
read    ifrSr       D 84 84
read    srData      A FF B6

/* src.f */
+incdir+hdl
hdl/viaPkg.sv
hdl/viaEdgeDetect.sv
hdl/viaTimer1.sv
hdl/viaShifter.sv
hdl/viaRegisterFile.sv
hdl/viaTop.sv
test/viaTb.sv

/* Bender.yml */
package:
  name: via

export_include_dirs:
  - hdl

sources:
  - hdl/viaPkg.sv
  - hdl/viaEdgeDetect.sv
  - hdl/viaTimer1.sv
  - hdl/viaShifter.sv
  - hdl/viaRegisterFile.sv
  - hdl/viaTop.sv
  - target: test
    files:
      - test/viaTb.sv
